// ==== Bender.yml ====
package:
  name: mz_fpga

sources:
  - logic/mz_bus_pkg.sv
  - logic/vd_regs_pkg.sv
  - logic/mz_bus_ctrl.sv
  - logic/ctrl_regs.sv
  - logic/buffer_ram.sv
  - logic/readback_unit.sv
  - logic/mz_fpga_top.sv
  - target: simulation
    files:
      - tb/tb_mz_fpga_top.sv

// ==== build.f ====
logic/mz_bus_pkg.sv
logic/vd_regs_pkg.sv
logic/mz_bus_ctrl.sv
logic/ctrl_regs.sv
logic/buffer_ram.sv
logic/readback_unit.sv
logic/mz_fpga_top.sv
tb/tb_mz_fpga_top.sv

// ==== logic/buffer_ram.sv ====
`timescale 1ns/100ps

module buffer_ram
  import mz_bus_pkg::*;
(
  input  logic                  clk,
  input  logic                  ram_en,
  input  logic [lanes-1:0]      ram_we,        // One bit per byte lane
  input  logic [word_idx_w-1:0] ram_word_idx,
  input  logic [data_w-1:0]     wr_data,
  output logic [data_w-1:0]     ram_rdata
);

  logic [data_w-1:0] mem [ram_words];  // Maps onto block RAM

  // ----------------------------------------
  // Single port, read first
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (ram_en) begin
      for (int i = 0; i < lanes; i++) begin
        if (ram_we[i]) begin
          mem[ram_word_idx][i*lane_w +: lane_w] <= wr_data[i*lane_w +: lane_w];
        end
      end
      ram_rdata <= mem[ram_word_idx];  // Valid next cycle
    end
  end

endmodule

// ==== logic/ctrl_regs.sv ====
`timescale 1ns/100ps

module ctrl_regs
  import mz_bus_pkg::*;
  import vd_regs_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              reg_wr_en,
  input  logic [7:0]        reg_offset,
  input  logic [data_w-1:0] wr_data,
  output logic [data_w-1:0] reg_rdata,
  output logic [7:0]        run_led
);

  logic [data_w-1:0]    regs [reg_count];  // Parameter registers
  logic [reg_idx_w-1:0] sel_idx;
  logic                 sel_hit;           // Offset is mapped

  // ----------------------------------------
  // Offset decode
  // ----------------------------------------
  always_comb begin
    sel_hit = 1'b1;
    case (reg_offset)
      off_run:    sel_idx = reg_idx_w'(0);  // Run register sits at index 0
      off_ncs:    sel_idx = reg_idx_w'(1);
      off_nct:    sel_idx = reg_idx_w'(2);
      off_n1:     sel_idx = reg_idx_w'(3);
      off_n2:     sel_idx = reg_idx_w'(4);
      off_nnobpa: sel_idx = reg_idx_w'(5);
      off_nnobpb: sel_idx = reg_idx_w'(6);
      off_pppa:   sel_idx = reg_idx_w'(7);
      off_pppb:   sel_idx = reg_idx_w'(8);
      off_lvl:    sel_idx = reg_idx_w'(9);
      default: begin
        sel_hit = 1'b0;                     // Hole in the map
        sel_idx = '0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_wr_en && sel_hit) begin
      regs[sel_idx] <= wr_data;
    end
  end

  // Unmapped offsets read as zero
  assign reg_rdata = sel_hit ? regs[sel_idx] : '0;

  assign run_led = regs[0][7:0];  // Low byte of run

endmodule

// ==== logic/mz_bus_ctrl.sv ====
`timescale 1ns/100ps

module mz_bus_ctrl
  import mz_bus_pkg::*;
  import vd_regs_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [addr_w-1:0]     bus_addr,
  input  logic                  as,           // Async strobe from the CPLD
  input  logic                  rw,           // High for read
  input  logic [lanes-1:0]      byte_n,       // Active low lane enables
  output logic                  dtack,
  output logic                  reg_wr_en,
  output logic [7:0]            reg_offset,
  output logic                  ram_en,
  output logic [lanes-1:0]      ram_we,
  output logic [word_idx_w-1:0] ram_word_idx,
  output logic                  cap_reg,
  output logic                  cap_ram,
  output logic                  cap_op_a,
  output logic                  cap_op_b,
  output logic                  cap_sum
);

  logic [sync_stages-1:0] as_sync;   // Strobe synchronizer chain
  logic                   as_det;    // Qualified strobe
  logic [st_w-1:0]        state;
  bus_addr_u              addr_q;    // Latched address
  logic                   rw_q;
  logic [lanes-1:0]       byte_n_q;
  logic                   is_reg;    // Register block selected
  logic                   is_sum;    // Read of the sum trigger word

  // ----------------------------------------
  // Strobe synchronizer
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      as_sync <= '0;
    end else begin
      as_sync <= {as_sync[sync_stages-2:0], as};  // Shift in live pin
    end
  end

  // All stages high plus live pin, so release is seen at once
  assign as_det = (&as_sync) && as;

  // Address and direction held for the whole access
  always_ff @(posedge clk) begin
    if (state == st_latch) begin
      addr_q   <= bus_addr;
      rw_q     <= rw;
      byte_n_q <= byte_n;
    end
  end

  // Region from the register view, trigger from the buffer view
  assign is_reg = (addr_q.regv.block == reg_block);
  assign is_sum = !is_reg && rw_q &&
                  (addr_q.bufv.word_idx == word_idx_w'(sum_trigger_idx));

  assign reg_offset = addr_q.regv.offset;

  // ----------------------------------------
  // Access FSM
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
      dtack <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (as_det) state <= st_latch;
        end
        st_latch:  state <= st_access;
        st_access: begin
          if (is_sum) begin
            state <= st_sum_rd_a;       // Word 0 read turns into a sum
          end else if (rw_q) begin
            state <= st_capture;
          end else begin
            state <= st_ack;            // Writes are done in one cycle
          end
        end
        st_capture:   state <= st_ack;
        st_sum_rd_a:  state <= st_sum_cap_a;
        st_sum_cap_a: state <= st_sum_rd_b;
        st_sum_rd_b:  state <= st_sum_cap_b;
        st_sum_cap_b: state <= st_sum;
        st_sum:       state <= st_ack;
        st_ack: begin
          dtack <= 1'b1;
          state <= st_hold;
        end
        st_hold: begin
          if (!as_det) begin            // Master released the strobe
            dtack <= 1'b0;
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Strobes decoded from state, one cycle each
  always_comb begin
    reg_wr_en    = 1'b0;
    ram_en       = 1'b0;
    ram_we       = '0;
    ram_word_idx = addr_q.bufv.word_idx;
    cap_reg      = 1'b0;
    cap_ram      = 1'b0;
    cap_op_a     = 1'b0;
    cap_op_b     = 1'b0;
    cap_sum      = 1'b0;
    case (state)
      st_access: begin
        if (is_reg) begin
          reg_wr_en = !rw_q;            // Register read needs no strobe here
        end else if (!is_sum) begin
          ram_en = 1'b1;
          ram_we = rw_q ? '0 : ~byte_n_q;
        end
      end
      st_capture: begin
        cap_reg = is_reg;
        cap_ram = !is_reg;
      end
      st_sum_rd_a: begin
        ram_en       = 1'b1;
        ram_word_idx = word_idx_w'(sum_idx_a);
      end
      st_sum_cap_a: cap_op_a = 1'b1;
      st_sum_rd_b: begin
        ram_en       = 1'b1;
        ram_word_idx = word_idx_w'(sum_idx_b);
      end
      st_sum_cap_b: cap_op_b = 1'b1;
      st_sum:       cap_sum  = 1'b1;
      default: ;
    endcase
  end

endmodule

// ==== logic/mz_bus_pkg.sv ====
package mz_bus_pkg;

  // ----------------------------------------
  // Bus geometry
  // ----------------------------------------
  localparam int addr_w      = 24;             // Mezzanine address lines
  localparam int data_w      = 32;             // Shared data bus
  localparam int lanes       = 4;              // Byte enables per word
  localparam int lane_w      = data_w / lanes; // Bits per byte lane
  localparam int ram_words   = 512;            // Buffer depth
  localparam int word_idx_w  = 9;              // log2 of buffer depth
  localparam int sync_stages = 2;              // Strobe synchronizer flops

  // DIP switch byte, copied once per lane on buffer reads
  localparam int dip_w = 8;

  // ----------------------------------------
  // Access FSM state codes
  // ----------------------------------------
  localparam int st_w = 4;
  localparam logic [st_w-1:0] st_idle      = 4'd0;  // Wait for strobe
  localparam logic [st_w-1:0] st_latch     = 4'd1;  // Grab address and rw
  localparam logic [st_w-1:0] st_access    = 4'd2;  // Reg write, RAM write or read issue
  localparam logic [st_w-1:0] st_capture   = 4'd3;  // Plain read capture
  localparam logic [st_w-1:0] st_sum_rd_a  = 4'd4;  // Read first addend
  localparam logic [st_w-1:0] st_sum_cap_a = 4'd5;
  localparam logic [st_w-1:0] st_sum_rd_b  = 4'd6;  // Read second addend
  localparam logic [st_w-1:0] st_sum_cap_b = 4'd7;
  localparam logic [st_w-1:0] st_sum       = 4'd8;  // Load the sum
  localparam logic [st_w-1:0] st_ack       = 4'd9;  // Raise dtack
  localparam logic [st_w-1:0] st_hold      = 4'd10; // Wait for strobe release

  // One latched address, seen as register offset or buffer word
  typedef union packed {
    struct packed {
      logic [addr_w-17:0] upper;    // Bits 23:16
      logic [3:0]         block;    // Bits 15:12, zero for registers
      logic [3:0]         unused;   // Bits 11:8
      logic [7:0]         offset;   // Register byte offset
    } regv;
    struct packed {
      logic [addr_w-word_idx_w-3:0] upper;    // Bits 23:11
      logic [word_idx_w-1:0]        word_idx; // Bits 10:2
      logic [1:0]                   byte_sel; // Byte within word
    } bufv;
  } bus_addr_u;

endpackage

// ==== logic/mz_fpga_top.sv ====
`timescale 1ns/100ps

module mz_fpga_top
  import mz_bus_pkg::*;
(
  input  logic              FPGA_CLK3,
  input  logic              SYS_RST_N,
  input  logic [addr_w-1:0] mz_buf_addr,
  inout  wire  [data_w-1:0] mz_buf_data,     // Shared with the mezzanine
  input  logic              mz_cpld_as,      // Address strobe, active high
  input  logic              mz_cpld_rw,      // High for read
  input  logic [lanes-1:0]  mz_cpld_byte_n,
  input  logic [dip_w-1:0]  dip_sw,
  output logic              fpga_mz_dtack,
  output logic [7:0]        led
);

  logic                  reg_wr_en;
  logic [7:0]            reg_offset;
  logic                  ram_en;
  logic [lanes-1:0]      ram_we;
  logic [word_idx_w-1:0] ram_word_idx;
  logic                  cap_reg;
  logic                  cap_ram;
  logic                  cap_op_a;
  logic                  cap_op_b;
  logic                  cap_sum;
  logic [data_w-1:0]     reg_rdata;
  logic [data_w-1:0]     ram_rdata;
  logic [data_w-1:0]     rd_data;

  // ----------------------------------------
  // Data bus driver
  // ----------------------------------------
  // Drive only during a read with strobe up
  assign mz_buf_data = (mz_cpld_rw && mz_cpld_as) ? rd_data : 'z;

  mz_bus_ctrl u_mz_bus_ctrl (
    .clk          (FPGA_CLK3),
    .rst_n        (SYS_RST_N),
    .bus_addr     (mz_buf_addr),
    .as           (mz_cpld_as),
    .rw           (mz_cpld_rw),
    .byte_n       (mz_cpld_byte_n),
    .dtack        (fpga_mz_dtack),
    .reg_wr_en    (reg_wr_en),
    .reg_offset   (reg_offset),
    .ram_en       (ram_en),
    .ram_we       (ram_we),
    .ram_word_idx (ram_word_idx),
    .cap_reg      (cap_reg),
    .cap_ram      (cap_ram),
    .cap_op_a     (cap_op_a),
    .cap_op_b     (cap_op_b),
    .cap_sum      (cap_sum)
  );

  ctrl_regs u_ctrl_regs (
    .clk        (FPGA_CLK3),
    .rst_n      (SYS_RST_N),
    .reg_wr_en  (reg_wr_en),
    .reg_offset (reg_offset),
    .wr_data    (mz_buf_data),  // Master drives data on writes
    .reg_rdata  (reg_rdata),
    .run_led    (led)
  );

  buffer_ram u_buffer_ram (
    .clk          (FPGA_CLK3),
    .ram_en       (ram_en),
    .ram_we       (ram_we),
    .ram_word_idx (ram_word_idx),
    .wr_data      (mz_buf_data),
    .ram_rdata    (ram_rdata)
  );

  readback_unit u_readback_unit (
    .clk       (FPGA_CLK3),
    .rst_n     (SYS_RST_N),
    .cap_reg   (cap_reg),
    .cap_ram   (cap_ram),
    .cap_op_a  (cap_op_a),
    .cap_op_b  (cap_op_b),
    .cap_sum   (cap_sum),
    .reg_rdata (reg_rdata),
    .ram_rdata (ram_rdata),
    .dip_sw    (dip_sw),
    .rd_data   (rd_data)
  );

endmodule

// ==== logic/readback_unit.sv ====
`timescale 1ns/100ps

module readback_unit
  import mz_bus_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              cap_reg,    // Take register readback
  input  logic              cap_ram,    // Take RAM word with DIP OR
  input  logic              cap_op_a,   // Load first addend
  input  logic              cap_op_b,   // Load second addend
  input  logic              cap_sum,    // Load the sum
  input  logic [data_w-1:0] reg_rdata,
  input  logic [data_w-1:0] ram_rdata,
  input  logic [dip_w-1:0]  dip_sw,
  output logic [data_w-1:0] rd_data
);

  logic [data_w-1:0] op_a;      // Raw RAM word, no DIP OR
  logic [data_w-1:0] op_b;
  logic [data_w-1:0] dip_word;  // Switch byte in every lane
  logic [data_w-1:0] sum;

  assign dip_word = {lanes{dip_sw}};

  // Wraps modulo 2^32, carry dropped
  assign sum = op_a + op_b;

  // ----------------------------------------
  // Sum operands
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (cap_op_a) begin
      op_a <= ram_rdata;
    end
    if (cap_op_b) begin
      op_b <= ram_rdata;
    end
  end

  // ----------------------------------------
  // Read data register
  // ----------------------------------------
  // Only one capture strobe is high in any cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_data <= '0;
    end else if (cap_reg) begin
      rd_data <= reg_rdata;             // Register value as stored
    end else if (cap_ram) begin
      rd_data <= ram_rdata | dip_word;  // Buffer word with switches
    end else if (cap_sum) begin
      rd_data <= sum;
    end
  end

endmodule

// ==== logic/vd_regs_pkg.sv ====
package vd_regs_pkg;

  // ----------------------------------------
  // Decoder parameter block
  // ----------------------------------------
  localparam logic [3:0] reg_block = 4'h0;  // Address bits 15:12 of the block

  localparam int reg_count = 10;                 // Mapped registers
  localparam int reg_idx_w = $clog2(reg_count);  // Index into register file

  // Byte offsets within the block
  localparam logic [7:0] off_run    = 8'h00;  // Run control, low byte on LEDs
  localparam logic [7:0] off_ncs    = 8'h10;  // Coding scheme
  localparam logic [7:0] off_nct    = 8'h14;  // Channel type
  localparam logic [7:0] off_n1     = 8'h18;
  localparam logic [7:0] off_n2     = 8'h1C;
  localparam logic [7:0] off_nnobpa = 8'h20;  // Out bits, part A
  localparam logic [7:0] off_nnobpb = 8'h24;  // Out bits, part B
  localparam logic [7:0] off_pppa   = 8'h28;  // Puncture pattern, part A
  localparam logic [7:0] off_pppb   = 8'h2C;  // Puncture pattern, part B
  localparam logic [7:0] off_lvl    = 8'h30;  // Level

  // ----------------------------------------
  // Sum read
  // ----------------------------------------
  // A read of the trigger word returns word a plus word b
  localparam int sum_trigger_idx = 0;
  localparam int sum_idx_a       = 1;
  localparam int sum_idx_b       = 2;

endpackage

// ==== tb/tb_mz_fpga_top.sv ====
`timescale 1ns/100ps

module tb_mz_fpga_top;

  localparam int max_rows   = 40;
  localparam int max_hold   = 3;   // Two LFSR bits per hold count
  localparam int rst_cycles = 8;
  localparam int ack_limit  = 32;  // Cycles allowed for one dtack edge

  logic        FPGA_CLK3;
  logic        SYS_RST_N;
  logic [23:0] mz_buf_addr;
  wire  [31:0] mz_buf_data;
  logic        mz_cpld_as;
  logic        mz_cpld_rw;
  logic [3:0]  mz_cpld_byte_n;
  logic [7:0]  dip_sw;
  logic        fpga_mz_dtack;
  logic [7:0]  led;
  logic [31:0] data_drv;          // Master side of the data bus
  logic        data_oe;

  // ----------------------------------------
  // Stimulus and expected values
  // ----------------------------------------
  logic        t_rw     [max_rows];
  logic [23:0] t_addr   [max_rows];
  logic [31:0] t_wdata  [max_rows];
  logic [3:0]  t_byte_n [max_rows];
  logic [7:0]  t_dip    [max_rows];
  int          t_hold   [max_rows];
  logic [31:0] t_exp    [max_rows];  // Read value, unused on writes
  logic [7:0]  t_led    [max_rows];  // LEDs after the row
  int          n_rows;
  logic        table_done;

  logic [31:0] reg_model [10];       // Parameter registers
  logic [31:0] mem_model [512];      // Buffer contents
  logic [31:0] lfsr;
  int          errors;
  int          checks;

  assign mz_buf_data = data_oe ? data_drv : 'z;

  mz_fpga_top u_mz_fpga_top (
    .FPGA_CLK3      (FPGA_CLK3),
    .SYS_RST_N      (SYS_RST_N),
    .mz_buf_addr    (mz_buf_addr),
    .mz_buf_data    (mz_buf_data),
    .mz_cpld_as     (mz_cpld_as),
    .mz_cpld_rw     (mz_cpld_rw),
    .mz_cpld_byte_n (mz_cpld_byte_n),
    .dip_sw         (dip_sw),
    .fpga_mz_dtack  (fpga_mz_dtack),
    .led            (led)
  );

  always #10 FPGA_CLK3 = ~FPGA_CLK3;  // 20 ns period

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return r;
  endfunction

  // Register slot for a byte offset, -1 for a hole
  function automatic int reg_index(input logic [7:0] off);
    if (off == 8'h00) return 0;
    if (off >= 8'h10 && off <= 8'h30 && off[1:0] == 2'b00) return (int'(off) - 16) / 4 + 1;
    return -1;
  endfunction

  function automatic logic [23:0] buf_addr(input int idx);
    return 24'h001000 | 24'(idx << 2);  // Block 1, word index in bits 10:2
  endfunction

  task automatic add_row(input logic rw, input logic [23:0] addr, input logic [31:0] wdata,
                         input logic [3:0] byte_n, input logic [7:0] dip);
    int         ri;
    logic [8:0] wi;
    logic       in_regs;
    in_regs = (addr[15:12] == 4'h0);
    ri      = reg_index(addr[7:0]);
    wi      = addr[10:2];
    t_rw[n_rows]     = rw;
    t_addr[n_rows]   = addr;
    t_wdata[n_rows]  = wdata;
    t_byte_n[n_rows] = byte_n;
    t_dip[n_rows]    = dip;
    t_hold[n_rows]   = int'(rand_bits(2));
    t_exp[n_rows]    = 32'h0;
    if (!rw) begin
      if (in_regs && ri >= 0) reg_model[ri] = wdata;
      if (!in_regs) begin
        for (int l = 0; l < 4; l++) begin
          if (!byte_n[l]) mem_model[wi][8*l +: 8] = wdata[8*l +: 8];  // Enabled lanes only
        end
      end
    end else if (in_regs) begin
      t_exp[n_rows] = (ri >= 0) ? reg_model[ri] : 32'h0;
    end else if (wi == 9'd0) begin
      t_exp[n_rows] = mem_model[1] + mem_model[2];  // Sum wraps, no DIP
    end else begin
      t_exp[n_rows] = mem_model[wi] | {4{dip}};
    end
    t_led[n_rows] = reg_model[0][7:0];
    n_rows++;
  endtask

  task automatic build_table();
    logic [7:0] offs [10];
    offs = '{8'h00, 8'h10, 8'h14, 8'h18, 8'h1C, 8'h20, 8'h24, 8'h28, 8'h2C, 8'h30};
    for (int i = 0; i < 10; i++) add_row(1'b0, {16'h0, offs[i]}, rand_bits(32), 4'h0, 8'h00);
    for (int i = 0; i < 10; i++) add_row(1'b1, {16'h0, offs[i]}, 32'h0, 4'h0, 8'h00);
    add_row(1'b1, 24'h000008, 32'h0, 4'h0, 8'h00);                // Hole in the map
    add_row(1'b0, buf_addr(5), rand_bits(32), 4'h0, 8'h00);
    add_row(1'b1, buf_addr(5), 32'h0, 4'h0, 8'h00);
    add_row(1'b1, buf_addr(5), 32'h0, 4'h0, 8'hA5);               // Switches on
    add_row(1'b0, buf_addr(5), rand_bits(32), 4'b0101, 8'h00);    // Lanes 1 and 3
    add_row(1'b1, buf_addr(5), 32'h0, 4'h0, 8'h00);
    add_row(1'b0, buf_addr(1), rand_bits(32), 4'h0, 8'h00);
    add_row(1'b0, buf_addr(2), rand_bits(32), 4'h0, 8'h00);
    add_row(1'b0, buf_addr(0), rand_bits(32), 4'h0, 8'h00);
    add_row(1'b1, buf_addr(0), 32'h0, 4'h0, 8'h3C);               // Sum read
    add_row(1'b0, buf_addr(300), rand_bits(32), 4'h0, 8'h00);
    add_row(1'b1, buf_addr(300), 32'h0, 4'h0, 8'(rand_bits(8)));
    add_row(1'b0, 24'h000000, rand_bits(32), 4'h0, 8'h00);        // New run value
  endtask

  // ----------------------------------------
  // Bus master, one four-phase cycle
  // ----------------------------------------
  task automatic run_row(input int r);
    int cnt;
    int err0;
    err0 = errors;
    @(negedge FPGA_CLK3);
    mz_buf_addr    = t_addr[r];
    mz_cpld_rw     = t_rw[r];
    mz_cpld_byte_n = t_byte_n[r];
    dip_sw         = t_dip[r];
    data_drv       = t_wdata[r];
    data_oe        = !t_rw[r];                   // Master drives only on writes
    mz_cpld_as     = 1'b1;
    cnt = 0;
    while (!fpga_mz_dtack && cnt < ack_limit) begin
      @(negedge FPGA_CLK3);
      cnt++;
    end
    checks++;
    if (!fpga_mz_dtack) begin
      $display("Row %0d: dtack never rose while the strobe was high", r);
      errors++;
    end else if (t_rw[r]) begin
      checks++;
      if (mz_buf_data !== t_exp[r]) begin
        $display("Error: row %0d mz_buf_data = %h, expected %h", r, mz_buf_data, t_exp[r]);
        errors++;
      end
    end
    for (int h = 0; h < t_hold[r]; h++) begin
      @(negedge FPGA_CLK3);
      if (!fpga_mz_dtack) begin
        $display("Row %0d: dtack fell while the strobe was still held", r);
        errors++;
      end
    end
    mz_cpld_as = 1'b0;
    data_oe    = 1'b0;
    cnt = 0;
    while (fpga_mz_dtack && cnt < ack_limit) begin
      @(negedge FPGA_CLK3);
      cnt++;
    end
    checks += 2;
    if (fpga_mz_dtack) begin
      $display("Row %0d: dtack stayed high after the strobe was released", r);
      errors++;
    end
    if (led !== t_led[r]) begin
      $display("Error: row %0d led = %h, expected %h", r, led, t_led[r]);
      errors++;
    end
    $display("Row %0d %s addr %h: %s", r, t_rw[r] ? "read " : "write", t_addr[r],
             (errors == err0) ? "ok" : "failed");
  endtask

  initial begin
    FPGA_CLK3      = 1'b0;
    SYS_RST_N      = 1'b0;
    mz_buf_addr    = '0;
    mz_cpld_as     = 1'b0;
    mz_cpld_rw     = 1'b1;
    mz_cpld_byte_n = 4'hF;
    dip_sw         = 8'h00;
    data_drv       = '0;
    data_oe        = 1'b0;
    lfsr           = 32'd40;  // Seed
    n_rows         = 0;
    errors         = 0;
    checks         = 0;
    table_done     = 1'b0;
    for (int i = 0; i < 10; i++) reg_model[i] = 32'h0;
    build_table();
    table_done = 1'b1;
    repeat (rst_cycles) @(posedge FPGA_CLK3);
    @(negedge FPGA_CLK3);
    SYS_RST_N = 1'b1;
    @(negedge FPGA_CLK3);
    checks += 2;
    if (fpga_mz_dtack !== 1'b0) begin
      $display("Error: fpga_mz_dtack = %h after reset, expected 0", fpga_mz_dtack);
      errors++;
    end
    if (led !== 8'h00) begin
      $display("Error: led = %h after reset, expected 00", led);
      errors++;
    end
    for (int r = 0; r < n_rows; r++) run_row(r);
    $display("%0d rows, %0d checks, %0d errors", n_rows, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Watchdog scaled by table length
  initial begin
    wait (table_done);
    repeat (rst_cycles + 2 + n_rows * (16 + max_hold)) @(posedge FPGA_CLK3);
    $display("Watchdog expired before all bus cycles finished");
    $display("Verification failed");
    $finish;
  end

endmodule
